// File: Bender.yml
package:
  name: rename_commit

sources:
  - files:
      - hdl/rf_pkg.sv
      - hdl/issue_control.sv
      - hdl/register_file.sv
      - hdl/rename_map.sv
      - hdl/rename_commit_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_rename_commit.sv

// File: hdl/issue_control.sv
//////////////////////////////////////////////////////////////////////
// run/drain control, one drain cycle follows every flush
// commits are never stalled, only dispatch is gated
//////////////////////////////////////////////////////////////////////

module issue_control (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   flush,
   input  rf_pkg::commit_slot_t   commit1,
   input  rf_pkg::commit_slot_t   commit2,
   input  rf_pkg::dispatch_slot_t dispatch1,
   input  rf_pkg::dispatch_slot_t dispatch2,
   output rf_pkg::rf_write_t      wr1,
   output rf_pkg::rf_write_t      wr2,
   output rf_pkg::rob_tag_t       commit_tag1,
   output rf_pkg::rob_tag_t       commit_tag2,
   output logic                   commit_tag_valid1,
   output logic                   commit_tag_valid2,
   output logic                   disp_en1,
   output logic                   disp_en2,
   output logic                   map_clear_all,
   output logic                   dispatch_ready
);

   import rf_pkg::*;

   ctrl_state_t state_q;

   // a flush while draining simply drains again
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state_q <= RUN;
      end
      else
      begin
         state_q <= flush ? DRAIN : RUN;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // dispatch gating
   //////////////////////////////////////////////////////////////////////

   assign dispatch_ready = !reset && (state_q == RUN);

   // the bundle in the flush cycle itself is dropped too
   assign disp_en1 = dispatch1.valid && dispatch_ready && !flush;
   assign disp_en2 = dispatch2.valid && dispatch_ready && !flush;

   assign map_clear_all = flush;

   //////////////////////////////////////////////////////////////////////
   // commit to write ports
   //////////////////////////////////////////////////////////////////////

   assign commit_tag_valid1 = commit1.valid && (commit1.dest != reg_idx_t'(ZERO_REG));
   assign commit_tag_valid2 = commit2.valid && (commit2.dest != reg_idx_t'(ZERO_REG));

   assign commit_tag1 = commit1.tag;
   assign commit_tag2 = commit2.tag;

   // idle slots become writes to register 0
   assign wr1.dest  = commit_tag_valid1 ? commit1.dest : reg_idx_t'(ZERO_REG);
   assign wr1.value = commit_tag_valid1 ? commit1.value : '0;
   assign wr2.dest  = commit_tag_valid2 ? commit2.dest : reg_idx_t'(ZERO_REG);
   assign wr2.value = commit_tag_valid2 ? commit2.value : '0;

endmodule

// File: hdl/register_file.sv
//////////////////////////////////////////////////////////////////////
// 2 write / 4 read register file, reads see this cycle's writes
// wr2 is the younger commit and wins when both target one register
//////////////////////////////////////////////////////////////////////

module register_file (
   input  logic              clock,
   input  logic              reset,

   // write ports from commit
   input  rf_pkg::rf_write_t wr1,
   input  rf_pkg::rf_write_t wr2,

   // read indices from the dispatch slots
   input  rf_pkg::reg_idx_t  rd1a,
   input  rf_pkg::reg_idx_t  rd1b,
   input  rf_pkg::reg_idx_t  rd2a,
   input  rf_pkg::reg_idx_t  rd2b,

   // forwarded read values
   output rf_pkg::reg_value_t val1a,
   output rf_pkg::reg_value_t val1b,
   output rf_pkg::reg_value_t val2a,
   output rf_pkg::reg_value_t val2b,

   // one flag per register written this cycle, for the rename map
   output rf_pkg::reg_mask_t clear_entries
);

   import rf_pkg::*;

   reg_value_t regs [NUM_REGS];

   // read value with forwarding from both write ports
   // the younger port is checked first
   function automatic reg_value_t read_port(
      input reg_idx_t   idx,
      input rf_write_t  w1,
      input rf_write_t  w2,
      input reg_value_t stored
   );
      reg_value_t result;
      if (idx == reg_idx_t'(ZERO_REG))
      begin
         result = '0;
      end
      else if (w2.dest == idx)
      begin
         result = w2.value;
      end
      else if (w1.dest == idx)
      begin
         result = w1.value;
      end
      else
      begin
         result = stored;
      end
      return result;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////////////////////////

   assign val1a = read_port(rd1a, wr1, wr2, regs[rd1a]);
   assign val1b = read_port(rd1b, wr1, wr2, regs[rd1b]);
   assign val2a = read_port(rd2a, wr1, wr2, regs[rd2a]);
   assign val2b = read_port(rd2b, wr1, wr2, regs[rd2b]);

   // a write to register 0 never flags anything
   always_comb
   begin
      clear_entries = '0;
      for (int j = 1; j < NUM_REGS; j++)
      begin
         clear_entries[j] = (wr1.dest == reg_idx_t'(j)) || (wr2.dest == reg_idx_t'(j));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////////////////////////

   // architectural state starts at zero
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int j = 0; j < NUM_REGS; j++)
         begin
            regs[j] <= '0;
         end
      end
      else
      begin
         regs[ZERO_REG] <= '0;
         for (int j = 1; j < NUM_REGS; j++)
         begin
            if (wr2.dest == reg_idx_t'(j))
            begin
               regs[j] <= wr2.value;
            end
            else if (wr1.dest == reg_idx_t'(j))
            begin
               regs[j] <= wr1.value;
            end
         end
      end
   end

endmodule

// File: hdl/rename_commit_top.sv
//////////////////////////////////////////////////////////////////////
// register state for a 2-wide core, tags come from outside
//////////////////////////////////////////////////////////////////////

module rename_commit_top (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   flush,
   input  rf_pkg::commit_slot_t   commit1,
   input  rf_pkg::commit_slot_t   commit2,
   input  rf_pkg::dispatch_slot_t dispatch1,
   input  rf_pkg::dispatch_slot_t dispatch2,
   output rf_pkg::operand_t       op1a,
   output rf_pkg::operand_t       op1b,
   output rf_pkg::operand_t       op2a,
   output rf_pkg::operand_t       op2b,
   output logic                   dispatch_ready
);

   import rf_pkg::*;

   // control to datapath
   rf_write_t  wr1;
   rf_write_t  wr2;
   rob_tag_t   commit_tag1;
   rob_tag_t   commit_tag2;
   logic       commit_tag_valid1;
   logic       commit_tag_valid2;
   logic       disp_en1;
   logic       disp_en2;
   logic       map_clear_all;

   // register file to rename map
   reg_value_t val1a;
   reg_value_t val1b;
   reg_value_t val2a;
   reg_value_t val2b;
   reg_mask_t  clear_entries;

   issue_control u_ctrl (
      .clock             (clock),
      .reset             (reset),
      .flush             (flush),
      .commit1           (commit1),
      .commit2           (commit2),
      .dispatch1         (dispatch1),
      .dispatch2         (dispatch2),
      .wr1               (wr1),
      .wr2               (wr2),
      .commit_tag1       (commit_tag1),
      .commit_tag2       (commit_tag2),
      .commit_tag_valid1 (commit_tag_valid1),
      .commit_tag_valid2 (commit_tag_valid2),
      .disp_en1          (disp_en1),
      .disp_en2          (disp_en2),
      .map_clear_all     (map_clear_all),
      .dispatch_ready    (dispatch_ready)
   );

   register_file u_rf (
      .clock         (clock),
      .reset         (reset),
      .wr1           (wr1),
      .wr2           (wr2),
      .rd1a          (dispatch1.rega),
      .rd1b          (dispatch1.regb),
      .rd2a          (dispatch2.rega),
      .rd2b          (dispatch2.regb),
      .val1a         (val1a),
      .val1b         (val1b),
      .val2a         (val2a),
      .val2b         (val2b),
      .clear_entries (clear_entries)
   );

   rename_map u_map (
      .clock             (clock),
      .reset             (reset),
      .dispatch1         (dispatch1),
      .dispatch2         (dispatch2),
      .disp_en1          (disp_en1),
      .disp_en2          (disp_en2),
      .commit_tag1       (commit_tag1),
      .commit_tag2       (commit_tag2),
      .commit_tag_valid1 (commit_tag_valid1),
      .commit_tag_valid2 (commit_tag_valid2),
      .clear_entries     (clear_entries),
      .clear_all         (map_clear_all),
      .val1a             (val1a),
      .val1b             (val1b),
      .val2a             (val2a),
      .val2b             (val2b),
      .op1a              (op1a),
      .op1b              (op1b),
      .op2a              (op2a),
      .op2b              (op2b)
   );

endmodule

// File: hdl/rename_map.sv
//////////////////////////////////////////////////////////////////////
// busy/tag table per architectural register, register 0 never busy
// an entry clears only when its stored tag matches a committing tag
//////////////////////////////////////////////////////////////////////

module rename_map (
   input  logic                   clock,
   input  logic                   reset,

   // dispatch bundle and its accept strobes
   input  rf_pkg::dispatch_slot_t dispatch1,
   input  rf_pkg::dispatch_slot_t dispatch2,
   input  logic                   disp_en1,
   input  logic                   disp_en2,

   // commit information
   input  rf_pkg::rob_tag_t       commit_tag1,
   input  rf_pkg::rob_tag_t       commit_tag2,
   input  logic                   commit_tag_valid1,
   input  logic                   commit_tag_valid2,
   input  rf_pkg::reg_mask_t      clear_entries,
   input  logic                   clear_all,

   // forwarded values from the register file
   input  rf_pkg::reg_value_t     val1a,
   input  rf_pkg::reg_value_t     val1b,
   input  rf_pkg::reg_value_t     val2a,
   input  rf_pkg::reg_value_t     val2b,

   output rf_pkg::operand_t       op1a,
   output rf_pkg::operand_t       op1b,
   output rf_pkg::operand_t       op2a,
   output rf_pkg::operand_t       op2b
);

   import rf_pkg::*;

   reg_mask_t busy_q;
   rob_tag_t  tag_q [NUM_REGS];

   // entries retired this cycle, and what is still busy after that
   reg_mask_t clear_hit;
   reg_mask_t live_busy;

   // slot 2 sources that depend on slot 1 in the same bundle
   logic dep2a;
   logic dep2b;

   // operand from the table state and the in-bundle dependency
   function automatic operand_t build_operand(
      input logic       busy,
      input rob_tag_t   stored_tag,
      input logic       dep_hit,
      input rob_tag_t   dep_tag,
      input reg_value_t value
   );
      operand_t op;
      op = '0;
      if (dep_hit)
      begin
         op.tag = dep_tag;
      end
      else if (busy)
      begin
         op.tag = stored_tag;
      end
      else
      begin
         op.ready = 1'b1;
         op.value = value;
      end
      return op;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // same-cycle clearing
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int j = 0; j < NUM_REGS; j++)
      begin
         clear_hit[j] = clear_entries[j] && busy_q[j] &&
                        ((commit_tag_valid1 && (tag_q[j] == commit_tag1)) ||
                         (commit_tag_valid2 && (tag_q[j] == commit_tag2)));
      end
   end

   assign live_busy = busy_q & ~clear_hit;

   //////////////////////////////////////////////////////////////////////
   // operand assembly
   //////////////////////////////////////////////////////////////////////

   // based on slot 1 valid so a held bundle reads the same every cycle
   assign dep2a = dispatch1.valid && (dispatch1.dest != reg_idx_t'(ZERO_REG)) &&
                  (dispatch2.rega == dispatch1.dest);
   assign dep2b = dispatch1.valid && (dispatch1.dest != reg_idx_t'(ZERO_REG)) &&
                  (dispatch2.regb == dispatch1.dest);

   assign op1a = build_operand(live_busy[dispatch1.rega], tag_q[dispatch1.rega],
                               1'b0, dispatch1.tag, val1a);
   assign op1b = build_operand(live_busy[dispatch1.regb], tag_q[dispatch1.regb],
                               1'b0, dispatch1.tag, val1b);
   assign op2a = build_operand(live_busy[dispatch2.rega], tag_q[dispatch2.rega],
                               dep2a, dispatch1.tag, val2a);
   assign op2b = build_operand(live_busy[dispatch2.regb], tag_q[dispatch2.regb],
                               dep2b, dispatch1.tag, val2b);

   //////////////////////////////////////////////////////////////////////
   // table update
   //////////////////////////////////////////////////////////////////////

   // flush first, then marking, then tag-matched clear
   always_ff @(posedge clock)
   begin
      if (reset || clear_all)
      begin
         busy_q <= '0;
      end
      else
      begin
         busy_q[ZERO_REG] <= 1'b0;
         for (int j = 1; j < NUM_REGS; j++)
         begin
            if ((disp_en2 && (dispatch2.dest == reg_idx_t'(j))) ||
                (disp_en1 && (dispatch1.dest == reg_idx_t'(j))))
            begin
               busy_q[j] <= 1'b1;
            end
            else if (clear_hit[j])
            begin
               busy_q[j] <= 1'b0;
            end
         end
      end
   end

   // tags only mean something while busy; slot 2 is younger
   always_ff @(posedge clock)
   begin
      for (int j = 1; j < NUM_REGS; j++)
      begin
         if (disp_en2 && (dispatch2.dest == reg_idx_t'(j)))
         begin
            tag_q[j] <= dispatch2.tag;
         end
         else if (disp_en1 && (dispatch1.dest == reg_idx_t'(j)))
         begin
            tag_q[j] <= dispatch1.tag;
         end
      end
   end

endmodule

// File: hdl/rf_pkg.sv
//////////////////////////////////////////////////////////////////////
// widths and types shared by the register file and rename map
// register 0 is hardwired to zero; a write to it means no write
//////////////////////////////////////////////////////////////////////

package rf_pkg;

   localparam int NUM_REGS     = 32;
   localparam int REG_IDX_BITS = 5;
   localparam int VALUE_BITS   = 64;
   localparam int TAG_BITS     = 4;
   localparam int ZERO_REG     = 0;

   // plain vector types
   typedef logic [REG_IDX_BITS-1:0] reg_idx_t;
   typedef logic [VALUE_BITS-1:0]   reg_value_t;
   typedef logic [TAG_BITS-1:0]     rob_tag_t;
   typedef logic [NUM_REGS-1:0]     reg_mask_t;

   //////////////////////////////////////////////////////////////////////
   // slot structs
   //////////////////////////////////////////////////////////////////////

   // one retiring result from the reorder buffer
   typedef struct packed {
      logic       valid;
      reg_idx_t   dest;
      rob_tag_t   tag;
      reg_value_t value;
   } commit_slot_t;

   // one decoded instruction entering rename
   typedef struct packed {
      logic     valid;
      reg_idx_t rega;
      reg_idx_t regb;
      reg_idx_t dest;
      rob_tag_t tag;
   } dispatch_slot_t;

   // register file write port, dest of ZERO_REG is an idle port
   typedef struct packed {
      reg_idx_t   dest;
      reg_value_t value;
   } rf_write_t;

   // source operand handed to the reservation stations
   // ready=1 carries a value, ready=0 carries the producer tag
   typedef struct packed {
      logic       ready;
      rob_tag_t   tag;
      reg_value_t value;
   } operand_t;

   // control states
   typedef enum logic {
      RUN   = 1'b0,
      DRAIN = 1'b1
   } ctrl_state_t;

endpackage

// File: sources.f
+incdir+verif
hdl/rf_pkg.sv
hdl/issue_control.sv
hdl/register_file.sv
hdl/rename_map.sv
hdl/rename_commit_top.sv
verif/tb_rename_commit.sv

// File: verif/rename_model.svh
//////////////////////////////////////////////////////////////////////
// register values and busy tags as the reservation stations expect
// included in the testbench body, uses its stimulus signals directly
//////////////////////////////////////////////////////////////////////

`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

reg_value_t ref_value [NUM_REGS];
logic       ref_busy [NUM_REGS];
rob_tag_t   ref_tag [NUM_REGS];
logic       in_drain;

task automatic check_equal(input string name,
                           input logic [$bits(operand_t)-1:0] expected,
                           input logic [$bits(operand_t)-1:0] actual);
   if (actual !== expected)
   begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first wrong value");
   end
endtask

function automatic void reset_model();
   for (int r = 0; r < NUM_REGS; r++)
   begin
      ref_value[r] = '0;
      ref_busy[r] = 1'b0;
      ref_tag[r] = '0;
   end
   in_drain = 1'b0;
endfunction

// a slot aimed at register 0 is an idle slot
function automatic logic slot_writes(input commit_slot_t s, input reg_idx_t r);
   return s.valid && (s.dest == r) && (r != reg_idx_t'(ZERO_REG));
endfunction

function automatic logic slot_retires(input commit_slot_t s, input rob_tag_t t);
   return s.valid && (s.dest != reg_idx_t'(ZERO_REG)) && (s.tag == t);
endfunction

// younger commit overrides the older one
function automatic reg_value_t committed_value(input reg_idx_t r);
   return slot_writes(commit2, r) ? commit2.value :
          slot_writes(commit1, r) ? commit1.value : ref_value[r];
endfunction

function automatic logic is_cleared(input reg_idx_t r);
   logic written;
   written = slot_writes(commit1, r) || slot_writes(commit2, r);
   return written && ref_busy[r] &&
          (slot_retires(commit1, ref_tag[r]) || slot_retires(commit2, ref_tag[r]));
endfunction

// slot 2 source produced by slot 1 of the same bundle
function automatic logic bundle_dep(input reg_idx_t src);
   return dispatch1.valid && (dispatch1.dest != reg_idx_t'(ZERO_REG)) &&
          (src == dispatch1.dest);
endfunction

function automatic operand_t expected_operand(input reg_idx_t src, input logic dep);
   operand_t op;
   op = '0;
   if (dep)
   begin
      op.tag = dispatch1.tag;
   end
   else if (ref_busy[src] && !is_cleared(src))
   begin
      op.tag = ref_tag[src];
   end
   else
   begin
      op.ready = 1'b1;
      op.value = committed_value(src);
   end
   return op;
endfunction

// state after the rising edge: values, then clear, then mark
function automatic void advance_model();
   logic cleared [NUM_REGS];
   logic accept;
   for (int r = 0; r < NUM_REGS; r++)
   begin
      cleared[r] = is_cleared(reg_idx_t'(r));
   end
   accept = !in_drain && !flush;
   for (int r = 1; r < NUM_REGS; r++)
   begin
      ref_value[r] = committed_value(reg_idx_t'(r));
      ref_busy[r] = flush ? 1'b0 : (ref_busy[r] && !cleared[r]);
   end
   if (accept && dispatch1.valid && (dispatch1.dest != reg_idx_t'(ZERO_REG)))
   begin
      ref_busy[dispatch1.dest] = 1'b1;
      ref_tag[dispatch1.dest] = dispatch1.tag;
   end
   // slot 2 marks last and so wins an equal dest
   if (accept && dispatch2.valid && (dispatch2.dest != reg_idx_t'(ZERO_REG)))
   begin
      ref_busy[dispatch2.dest] = 1'b1;
      ref_tag[dispatch2.dest] = dispatch2.tag;
   end
   in_drain = flush;
endfunction

`endif

// File: verif/tb_rename_commit.sv
//////////////////////////////////////////////////////////////////////
// seeded random test of rename_commit_top, the bench acts as the ROB
// inputs change on the falling edge, outputs checked in the low phase
//////////////////////////////////////////////////////////////////////

module tb_rename_commit;

   import rf_pkg::*;

   localparam int RESET_CYCLES  = 16;
   localparam int WAKE_CYCLES   = 8;
   localparam int COMMIT_CYCLES = 200;
   localparam int FWD_CYCLES    = 100;
   localparam int RENAME_CYCLES = 300;
   localparam int FLUSH_CYCLES  = 200;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + WAKE_CYCLES + COMMIT_CYCLES +
                                  FWD_CYCLES + RENAME_CYCLES + FLUSH_CYCLES;

   logic           clock;
   logic           reset;
   logic           flush;
   commit_slot_t   commit1;
   commit_slot_t   commit2;
   dispatch_slot_t dispatch1;
   dispatch_slot_t dispatch2;
   operand_t       op1a;
   operand_t       op1b;
   operand_t       op2a;
   operand_t       op2b;
   logic           dispatch_ready;

   string test_name;
   int    cycle_count;

   `include "rename_model.svh"

   rename_commit_top u_dut (
      .clock          (clock),
      .reset          (reset),
      .flush          (flush),
      .commit1        (commit1),
      .commit2        (commit2),
      .dispatch1      (dispatch1),
      .dispatch2      (dispatch2),
      .op1a           (op1a),
      .op1b           (op1b),
      .op2a           (op2a),
      .op2b           (op2b),
      .dispatch_ready (dispatch_ready)
   );

   initial
   begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < TOTAL_CYCLES + 100)
      begin
         @(posedge clock);
         cycle_count++;
      end
      $display("timeout, the run went past %0d cycles", cycle_count);
      $display("TEST FAIL");
      $fatal(1, "run did not finish in time");
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus and checking
   //////////////////////////////////////////////////////////////////////

   function automatic commit_slot_t random_commit(input int top_reg, input logic live_tag);
      commit_slot_t s;
      s.valid = ($urandom_range(0, 3) != 0);
      s.dest = reg_idx_t'($urandom_range(0, top_reg));
      s.value = {$urandom, $urandom};
      s.tag = rob_tag_t'($urandom);
      // often retire the producer the table is waiting on
      if (live_tag && ref_busy[s.dest] && ($urandom_range(0, 1) != 0))
      begin
         s.tag = ref_tag[s.dest];
      end
      return s;
   endfunction

   function automatic dispatch_slot_t random_dispatch(input int top_reg);
      dispatch_slot_t s;
      s.valid = ($urandom_range(0, 1) != 0);
      s.rega = reg_idx_t'($urandom_range(0, top_reg));
      s.regb = reg_idx_t'($urandom_range(0, top_reg));
      s.dest = reg_idx_t'($urandom_range(0, top_reg));
      s.tag = rob_tag_t'($urandom);
      return s;
   endfunction

   task automatic check_outputs();
      check_equal({test_name, " dispatch_ready"}, !in_drain, dispatch_ready);
      check_equal({test_name, " op1a"}, expected_operand(dispatch1.rega, 1'b0), op1a);
      check_equal({test_name, " op1b"}, expected_operand(dispatch1.regb, 1'b0), op1b);
      check_equal({test_name, " op2a"},
                  expected_operand(dispatch2.rega, bundle_dep(dispatch2.rega)), op2a);
      check_equal({test_name, " op2b"},
                  expected_operand(dispatch2.regb, bundle_dep(dispatch2.regb)), op2b);
   endtask

   // called just after a falling edge with the inputs already set
   task automatic run_cycle();
      #1;
      check_outputs();
      advance_model();
      @(negedge clock);
   endtask

   // small register range so renames collide often
   task automatic mixed_cycles(input int count, input logic with_flush);
      for (int k = 0; k < count; k++)
      begin
         commit1 = random_commit(7, 1'b1);
         commit2 = random_commit(7, 1'b1);
         dispatch1 = random_dispatch(7);
         dispatch2 = random_dispatch(7);
         flush = with_flush && ($urandom_range(0, 7) == 0);
         run_cycle();
      end
   endtask

   initial
   begin
      void'($urandom(32'h770));
      reset = 1'b1;
      flush = 1'b0;
      commit1 = '0;
      commit2 = '0;
      dispatch1 = '0;
      dispatch2 = '0;
      test_name = "reset";
      repeat (RESET_CYCLES)
      begin
         @(posedge clock);
         #1;
         check_equal({test_name, " dispatch_ready"}, '0, dispatch_ready);
      end
      @(negedge clock);
      reset = 1'b0;
      reset_model();

      // sweep all 32 registers, four per cycle
      test_name = "after_reset";
      for (int k = 0; k < WAKE_CYCLES; k++)
      begin
         dispatch1.rega = reg_idx_t'(4 * k);
         dispatch1.regb = reg_idx_t'(4 * k + 1);
         dispatch2.rega = reg_idx_t'(4 * k + 2);
         dispatch2.regb = reg_idx_t'(4 * k + 3);
         run_cycle();
      end

      test_name = "random_commit";
      for (int k = 0; k < COMMIT_CYCLES; k++)
      begin
         commit1 = random_commit(NUM_REGS - 1, 1'b0);
         commit2 = random_commit(NUM_REGS - 1, 1'b0);
         dispatch1 = random_dispatch(NUM_REGS - 1);
         dispatch2 = random_dispatch(NUM_REGS - 1);
         dispatch1.valid = 1'b0;
         dispatch2.valid = 1'b0;
         run_cycle();
      end

      // reads aimed at the registers being committed right now
      test_name = "forwarding";
      for (int k = 0; k < FWD_CYCLES; k++)
      begin
         commit1 = random_commit(NUM_REGS - 1, 1'b0);
         commit2 = random_commit(NUM_REGS - 1, 1'b0);
         if ($urandom_range(0, 1) != 0)
         begin
            commit2.dest = commit1.dest;
         end
         dispatch1 = random_dispatch(NUM_REGS - 1);
         dispatch2 = random_dispatch(NUM_REGS - 1);
         dispatch1.valid = 1'b0;
         dispatch2.valid = 1'b0;
         dispatch1.rega = commit1.dest;
         dispatch1.regb = commit2.dest;
         dispatch2.rega = commit2.dest;
         run_cycle();
      end

      test_name = "renaming";
      mixed_cycles(RENAME_CYCLES, 1'b0);

      test_name = "flush";
      mixed_cycles(FLUSH_CYCLES, 1'b1);

      $display("TEST PASS");
      $finish;
   end

endmodule
